// File: common/snap_params.svh
`ifndef SNAP_PARAMS_SVH
`define SNAP_PARAMS_SVH

// register bus side
`define SNAP_BUS_DATA_W 32
`define SNAP_BUS_ADDR_W 32

// wide memory side, lane count follows from the two data widths
`define SNAP_MEM_DATA_W 64
`define SNAP_MEM_ADDR_W 8

// cycles from the rise of the memory request to its acknowledge, 1 or more
`define SNAP_MEM_LATENCY 3

`endif

// File: common/snap_pkg.sv
`default_nettype none

`include "snap_params.svh"

package snap_pkg;

    typedef enum logic [2:0] {
        idle         = 3'b001,
        acc_mem      = 3'b010, // lane 0 access waiting on the memory
        acc_snapshot = 3'b100  // upper lane access served from the snapshot
    } snap_state_e;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_e;

    typedef struct packed {
        logic                        vld;
        logic                        wr_en;
        logic                        rd_en;
        logic [`SNAP_BUS_ADDR_W-1:0] addr;   // byte address
        logic [`SNAP_BUS_DATA_W-1:0] wr_data;
    } bus_req_t;

    typedef struct packed {
        logic                        vld;
        mem_op_e                     op;
        logic [`SNAP_MEM_ADDR_W-1:0] addr;   // word index
        logic [`SNAP_MEM_DATA_W-1:0] wr_data;
    } mem_req_t;

endpackage

`default_nettype wire

// File: snapshot/snapshot_bridge.sv
`default_nettype none

`include "snap_params.svh"

module snapshot_bridge (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        soft_rst,
    input  snap_pkg::bus_req_t          bus_req,
    output logic                        ack_vld,
    output logic [`SNAP_BUS_DATA_W-1:0] rd_data,
    output snap_pkg::mem_req_t          mem_req,
    input  logic                        mem_ack_vld,
    input  logic [`SNAP_MEM_DATA_W-1:0] mem_rd_data
);

    localparam int bus_w      = `SNAP_BUS_DATA_W;
    localparam int mem_w      = `SNAP_MEM_DATA_W;
    localparam int lane_cnt   = mem_w / bus_w;
    localparam int lane_bytes = bus_w / 8;
    localparam int off_w      = $clog2(mem_w / 8);

    logic [off_w-1:0]                 byte_off;
    logic [lane_cnt-1:0]              lane_rd_en;
    logic [lane_cnt-1:0]              lane_wr_en;
    logic                             req_fire;
    logic                             mem_access;
    logic                             mem_done;
    logic                             capture;
    logic [lane_cnt-1:0]              snap_wr_en;

    logic [lane_cnt-1:0]              lane_rd_en_q;
    snap_pkg::mem_op_e                op_q;
    logic [`SNAP_MEM_ADDR_W-1:0]      word_addr_q;
    logic [bus_w-1:0]                 wr_data_q;
    logic [lane_cnt-1:0][bus_w-1:0]   snap_q;

    snap_pkg::snap_state_e            state_q;
    snap_pkg::snap_state_e            state_d;

    // lane decode from the byte offset

    assign byte_off = bus_req.addr[off_w-1:0];

    for (genvar i = 0; i < lane_cnt; i++) begin : g_lane_dec
        assign lane_rd_en[i] = bus_req.rd_en && (byte_off == off_w'(i * lane_bytes));
        assign lane_wr_en[i] = bus_req.wr_en && (byte_off == off_w'(i * lane_bytes));
    end

    // a request is only taken while idle, soft reset drops it
    assign req_fire   = bus_req.vld && (bus_req.wr_en || bus_req.rd_en) &&
                        (state_q == snap_pkg::idle) && !soft_rst;
    assign mem_access = lane_rd_en[0] || lane_wr_en[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_rd_en_q <= '0;
            op_q         <= snap_pkg::op_read;
        end else if (soft_rst) begin
            lane_rd_en_q <= '0;
            op_q         <= snap_pkg::op_read;
        end else if (req_fire) begin
            lane_rd_en_q <= lane_rd_en; // held until the next request so rd_data stays valid
            op_q         <= lane_wr_en[0] ? snap_pkg::op_write : snap_pkg::op_read;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            word_addr_q <= bus_req.addr[off_w +: `SNAP_MEM_ADDR_W];
            wr_data_q   <= bus_req.wr_data;
        end
    end

    // access state machine

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= snap_pkg::idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        if (soft_rst) begin
            state_d = snap_pkg::idle;
        end else begin
            case (state_q)
                snap_pkg::idle: begin
                    if (req_fire) begin
                        state_d = mem_access ? snap_pkg::acc_mem : snap_pkg::acc_snapshot;
                    end
                end
                snap_pkg::acc_mem: begin
                    if (mem_ack_vld) begin
                        state_d = snap_pkg::idle;
                    end
                end
                snap_pkg::acc_snapshot: begin
                    state_d = snap_pkg::idle; // snapshot lanes answer in one cycle
                end
                default: begin
                    state_d = snap_pkg::idle;
                end
            endcase
        end
    end

    assign mem_done = (state_q == snap_pkg::acc_mem) && mem_ack_vld;

    // snapshot registers
    // lane 0 is only ever loaded from memory, upper lanes also take bus writes
    assign capture    = mem_done && lane_rd_en_q[0] && !soft_rst;
    assign snap_wr_en = {lane_wr_en[lane_cnt-1:1] & {(lane_cnt - 1){req_fire}}, 1'b0};

    for (genvar i = 0; i < lane_cnt; i++) begin : g_snap
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                snap_q[i] <= '0;
            end else if (capture) begin
                snap_q[i] <= mem_rd_data[i*bus_w +: bus_w];
            end else if (snap_wr_en[i]) begin
                snap_q[i] <= bus_req.wr_data;
            end
        end
    end

    always_comb begin
        mem_req.vld     = (state_q == snap_pkg::acc_mem);
        mem_req.op      = op_q;
        mem_req.addr    = word_addr_q;
        mem_req.wr_data = {snap_q[lane_cnt-1:1], wr_data_q}; // upper lanes come from the snapshot
    end

    // acknowledge and read data return

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_vld <= 1'b0;
        end else if (soft_rst) begin
            ack_vld <= 1'b0;
        end else begin
            ack_vld <= mem_done || (req_fire && !mem_access);
        end
    end

    always_comb begin
        rd_data = '0;
        for (int i = 0; i < lane_cnt; i++) begin
            if (lane_rd_en_q[i]) begin
                rd_data = rd_data | snap_q[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/wide_mem.sv
`default_nettype none

`include "snap_params.svh"

module wide_mem (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        soft_rst,
    input  snap_pkg::mem_req_t          mem_req,
    output logic                        mem_ack_vld,
    output logic [`SNAP_MEM_DATA_W-1:0] mem_rd_data
);

    localparam int unsigned lat   = `SNAP_MEM_LATENCY;
    localparam int unsigned depth = 1 << `SNAP_MEM_ADDR_W;
    localparam int unsigned cnt_w = $clog2(lat + 1);
    localparam logic [cnt_w-1:0] ack_cnt = cnt_w'(lat - 1);

    logic [`SNAP_MEM_DATA_W-1:0] mem_q [depth];
    logic [cnt_w-1:0]            cnt_q;

    // counts the cycles the request has been up, so latency 1 acks at once
    assign mem_ack_vld = mem_req.vld && (cnt_q == ack_cnt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (soft_rst) begin
            cnt_q <= '0; // pending operation is abandoned
        end else if (mem_ack_vld) begin
            cnt_q <= '0;
        end else if (mem_req.vld) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_ack_vld && !soft_rst && (mem_req.op == snap_pkg::op_write)) begin
            mem_q[mem_req.addr] <= mem_req.wr_data;
        end
    end

    // read data is taken by the bridge in the acknowledge cycle
    assign mem_rd_data = mem_q[mem_req.addr];

endmodule

`default_nettype wire

// File: verilog/snapshot_top.sv
`default_nettype none

`include "snap_params.svh"

module snapshot_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        soft_rst,
    input  snap_pkg::bus_req_t          bus_req,
    output logic                        ack_vld,
    output logic [`SNAP_BUS_DATA_W-1:0] rd_data
);

    snap_pkg::mem_req_t          mem_req;
    logic                        mem_ack_vld;
    logic [`SNAP_MEM_DATA_W-1:0] mem_rd_data;

    snapshot_bridge u_bridge (
        .clk         (clk),
        .rst_n       (rst_n),
        .soft_rst    (soft_rst),
        .bus_req     (bus_req),
        .ack_vld     (ack_vld),
        .rd_data     (rd_data),
        .mem_req     (mem_req),
        .mem_ack_vld (mem_ack_vld),
        .mem_rd_data (mem_rd_data)
    );

    wide_mem u_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .soft_rst    (soft_rst),
        .mem_req     (mem_req),
        .mem_ack_vld (mem_ack_vld),
        .mem_rd_data (mem_rd_data)
    );

endmodule

`default_nettype wire

// File: sim/snapshot_props.sv
`default_nettype none

module snapshot_props (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  soft_rst,
    input snap_pkg::bus_req_t    bus_req,
    input logic                  ack_vld,
    input snap_pkg::mem_req_t    mem_req,
    input logic                  mem_ack_vld,
    input snap_pkg::snap_state_e state_q
);

    int unsigned fail_cnt = 0; // number of failed properties so far

    mem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.vld && !mem_ack_vld && !soft_rst |=> mem_req.vld)
        else begin
            fail_cnt++;
            $error("memory request dropped before its acknowledge");
        end

    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        ack_vld |=> !ack_vld)
        else begin
            fail_cnt++;
            $error("ack_vld held for two cycles");
        end

    req_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req.vld |-> state_q == snap_pkg::idle)
        else begin
            fail_cnt++;
            $error("bus request arrived while the bridge was busy");
        end

    rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(bus_req.wr_en && bus_req.rd_en))
        else begin
            fail_cnt++;
            $error("wr_en and rd_en set together");
        end

endmodule

bind snapshot_bridge snapshot_props u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .soft_rst    (soft_rst),
    .bus_req     (bus_req),
    .ack_vld     (ack_vld),
    .mem_req     (mem_req),
    .mem_ack_vld (mem_ack_vld),
    .state_q     (state_q)
);

`default_nettype wire

// File: sim/snapshot_tb.sv
`default_nettype none

`include "snap_params.svh"

module snapshot_tb;

    localparam int          lat        = `SNAP_MEM_LATENCY;
    localparam int          words      = 1 << `SNAP_MEM_ADDR_W;
    localparam int          bus_w      = `SNAP_BUS_DATA_W;
    localparam int          ack_bound  = lat + 4;
    localparam int          test_cnt   = 100; // upper bound on the bus operations in the run
    localparam int          sweep_cnt  = 16;
    localparam logic [31:0] seed       = 32'hbc69;
    localparam time         period     = 100;
    localparam time         reset_time = 6 * period;
    localparam time         wd_time    = test_cnt * (lat + 6) * period + reset_time;

    logic                        clk;
    logic                        rst_n;
    logic                        soft_rst;
    snap_pkg::bus_req_t          bus_req;
    logic                        ack_vld;
    logic [bus_w-1:0]            rd_data;

    logic [`SNAP_MEM_DATA_W-1:0] model_mem [words]; // expected memory contents
    logic [bus_w-1:0]            model_hi;          // expected upper snapshot lane
    int                          ack_wait;          // cycles from request to ack minus one

    snapshot_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .soft_rst (soft_rst),
        .bus_req  (bus_req),
        .ack_vld  (ack_vld),
        .rd_data  (rd_data)
    );

    always #(period / 2) clk = ~clk;

    initial begin
        #(wd_time);
        $display("Timeout: the tests did not finish in time");
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_data(input logic [bus_w-1:0] exp, input logic [bus_w-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("Fail at %0t: rd_data expected %h, actual %h",
                                    $time, exp, act));
        end
    endtask

    task automatic check_no_ack(input int cycles);
        repeat (cycles) begin
            if (ack_vld !== 1'b0) begin
                stop_on_error("ack_vld pulsed for an access that soft reset cancelled");
            end
            @(posedge clk);
            #10;
        end
    endtask

    // drives a one-cycle request pulse and returns in the cycle after it
    task automatic drive_req(input logic wr, input int word, input int lane,
                             input logic [bus_w-1:0] data);
        @(posedge clk);
        #10;
        bus_req.vld     = 1'b1;
        bus_req.wr_en   = wr;
        bus_req.rd_en   = !wr;
        bus_req.addr    = '0;
        bus_req.addr[3 +: `SNAP_MEM_ADDR_W] = word[`SNAP_MEM_ADDR_W-1:0];
        bus_req.addr[2] = (lane != 0); // byte offset 4 selects lane 1
        bus_req.wr_data = data;
        @(posedge clk);
        #10;
        bus_req = '0;
    endtask

    task automatic bus_access(input logic wr, input int word, input int lane,
                              input logic [bus_w-1:0] data);
        drive_req(wr, word, lane, data);
        ack_wait = 0;
        while (ack_vld !== 1'b1) begin
            if (ack_wait >= ack_bound) begin
                stop_on_error("no ack_vld within the bound after a bus request");
            end
            @(posedge clk);
            #10;
            ack_wait++;
        end
    endtask

    task automatic bus_write(input int word, input int lane, input logic [bus_w-1:0] data);
        bus_access(1'b1, word, lane, data);
        if (lane == 0) begin
            model_mem[word] = {model_hi, data};
        end else begin
            model_hi = data;
        end
    endtask

    task automatic bus_read(input int word, input int lane);
        logic [bus_w-1:0] exp;
        bus_access(1'b0, word, lane, '0);
        if (lane == 0) begin
            model_hi = model_mem[word][2*bus_w-1:bus_w];
            exp      = model_mem[word][bus_w-1:0];
        end else begin
            exp = model_hi;
        end
        check_data(exp, rd_data);
    endtask

    task automatic do_soft_rst(input int word, input logic [bus_w-1:0] data);
        drive_req(1'b1, word, 0, data);
        soft_rst = 1'b1; // memory write is pending here
        @(posedge clk);
        #10;
        soft_rst = 1'b0;
        check_no_ack(ack_bound);
    endtask

    task automatic write_word(input int word);
        bus_write(word, 1, $urandom());
        bus_write(word, 0, $urandom());
    endtask

    task automatic test_atomic_rw();
        logic [bus_w-1:0] lo;
        logic [bus_w-1:0] hi;
        lo = $urandom();
        hi = $urandom();
        bus_write(5, 1, hi);
        bus_write(5, 0, lo);
        bus_read(5, 0);
        check_data(lo, rd_data);
        bus_read(5, 1);
        check_data(hi, rd_data);
    endtask

    task automatic test_isolation();
        write_word(9);
        bus_read(9, 0);
        bus_write(9, 1, $urandom());
        bus_read(9, 1);
        bus_read(9, 0); // reload shows the lane 1 write stayed in the snapshot
        bus_read(9, 1);
    endtask

    task automatic test_consistency();
        write_word(20);
        bus_read(20, 0);
        bus_write(21, 0, $urandom());
        bus_read(21, 1);
        bus_write(21, 1, $urandom());
        bus_write(21, 0, $urandom());
        bus_read(21, 1);
        bus_read(21, 0);
        bus_read(21, 1);
    endtask

    task automatic test_fast_lane1();
        bus_write(40, 1, $urandom());
        if (ack_wait != 0) begin
            stop_on_error("lane 1 write was not acknowledged in the cycle after its request");
        end
        bus_read(40, 1);
        if (ack_wait != 0) begin
            stop_on_error("lane 1 read was not acknowledged in the cycle after its request");
        end
    endtask

    task automatic test_soft_reset();
        write_word(30);
        do_soft_rst(30, $urandom());
        bus_read(30, 0);
        bus_read(30, 1);
    endtask

    task automatic test_sweep();
        int idx [sweep_cnt];
        for (int i = 0; i < sweep_cnt; i++) begin
            idx[i] = $urandom_range(words - 1);
            write_word(idx[i]);
        end
        for (int i = 0; i < sweep_cnt; i++) begin
            bus_read(idx[i], 0);
            bus_read(idx[i], 1);
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        soft_rst = 1'b0;
        bus_req  = '0;
        model_hi = '0; // rst_n clears the snapshot
        ack_wait = 0;
        void'($urandom(seed));
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;
        test_atomic_rw();
        test_isolation();
        test_consistency();
        test_fast_lane1();
        test_soft_reset();
        test_sweep();
        @(posedge clk);
        #10;
        if (uut.u_bridge.u_props.fail_cnt != 0) begin
            $display("bridge assertions failed during the run");
            $display("TEST RESULT: FAIL");
            $fatal(1, "assertion failures");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+common
common/snap_pkg.sv
snapshot/snapshot_bridge.sv
verilog/wide_mem.sv
verilog/snapshot_top.sv
sim/snapshot_props.sv
sim/snapshot_tb.sv

// File: Makefile
VERILATOR  := verilator
TOP        := snapshot_tb
RTL_TOP    := snapshot_top
FILE_LIST  := list.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS   := +verilator+error+limit+100
FAIL_MSG   := TEST RESULT: FAIL
PASS_MSG   := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
